// File: pls_decoder.f
verilog/pls_dec_types_pkg.sv
verilog/pls_dec_frame_pkg.sv
verilog/pls_dec_if.sv
verilog/pls_dec_ctrl.sv
verilog/pls_rm_corr.sv
verilog/pls_max_sort.sv
verilog/pls_decoder.sv
verif/pls_decoder_tb.sv

// File: run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -Wno-fatal --top-module pls_decoder_tb -f pls_decoder.f \
  -o pls_decoder_sim > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/pls_decoder_sim > sim.log 2>&1
cat sim.log
grep -q "CHECKS FAILED" sim.log && exit 1
grep -q "ALL CHECKS PASSED" sim.log || exit 1
exit 0

// File: verif/pls_decoder_tb.sv
// pls decoder testbench: golden frames replayed with ival gaps, clock enable holes and back pressure
`timescale 1ns/1ps
`default_nettype none

module pls_decoder_tb import pls_dec_types_pkg::*, pls_dec_frame_pkg::*; ();

  // 32 pairs, then expected code and metric
  localparam int cFRAME_WORDS = cPAIR_NUM + 2;
  localparam int cFRAME_NUM   = 6;

  logic      iclk = 1'b0;
  logic      ireset;
  logic      iclkena;
  logic      isop;
  logic      ival;
  logic      ieop;
  soft_t     isoft_a;
  soft_t     isoft_b;
  logic      ordy;
  logic      ocode_val;
  pls_code_t ocode;
  metric_t   ometric;

  logic [11 : 0] golden_mem [cFRAME_NUM * cFRAME_WORDS];
  logic [31 : 0] lcg_state = 32'hb531;
  int            pulse_cnt = 0;
  int            chk_cnt   = 0;
  int            err_cnt   = 0;
  int            test_err  = 0;

  pls_decoder uut (
    .iclk      (iclk),
    .ireset    (ireset),
    .iclkena   (iclkena),
    .isop      (isop),
    .ival      (ival),
    .ieop      (ieop),
    .isoft_a   (isoft_a),
    .isoft_b   (isoft_b),
    .ordy      (ordy),
    .ocode_val (ocode_val),
    .ocode     (ocode),
    .ometric   (ometric)
  );

  // 8 ns period
  always #4 iclk = ~iclk;

  // one count per pulse, taken at the enabled edge that ends it
  always @(posedge iclk) begin
    if (iclkena && ocode_val) begin
      pulse_cnt <= pulse_cnt + 1;
    end
  end

  function automatic logic [31 : 0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // 0..99 from the better upper bits
  function automatic int lcg_pct();
    logic [31 : 0] r;
    r = lcg_next();
    return int'(r[30 : 16]) % 100;
  endfunction

  task automatic flag_error(input string msg);
    err_cnt++;
    $display("%s", msg);
  endtask

  task automatic check_code(input pls_code_t got, input pls_code_t exp);
    chk_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("Fail ocode: got 0x%h, expected 0x%h", got, exp);
    end
  endtask

  task automatic check_metric(input metric_t got, input metric_t exp);
    chk_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("Fail ometric: got 0x%h, expected 0x%h", got, exp);
    end
  endtask

  task automatic check_level(input string name, input logic got, input logic exp);
    chk_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("Fail %s: got 0x%h, expected 0x%h", name, got, exp);
    end
  endtask

  task automatic wait_ordy();
    int guard;
    guard = 0;
    while (!ordy && guard < 20) begin
      @(negedge iclk);
      guard++;
      iclkena = 1'b1;
    end
    if (!ordy) flag_error("timeout waiting for ordy after reset");
  endtask

  task automatic send_frame(input int f, input int gap_pct, input int hole_pct);
    int n;
    int guard;
    n     = 0;
    guard = 0;
    while (n < cPAIR_NUM && guard < 2000) begin
      @(negedge iclk);
      guard++;
      iclkena            = (lcg_pct() >= hole_pct);
      ival               = (lcg_pct() >= gap_pct);
      isop               = (n == 0);
      ieop               = (n == cPAIR_NUM - 1);
      {isoft_a, isoft_b} = golden_mem[f * cFRAME_WORDS + n];
      // ordy only moves on a clock edge, so the next edge sees this value
      if (ival && iclkena && ordy) begin
        n++;
      end
    end
    if (n < cPAIR_NUM) begin
      flag_error($sformatf("timeout sending frame %0d, %0d pairs taken", f, n));
    end
  endtask

  task automatic wait_result(input int hole_pct, input logic garbage, output logic seen,
                             output pls_code_t code, output metric_t metric);
    int            guard;
    logic [31 : 0] r;
    seen   = 1'b0;
    code   = '0;
    metric = '0;
    guard  = 0;
    while (!seen && guard < 400) begin
      @(negedge iclk);
      guard++;
      iclkena = (lcg_pct() >= hole_pct);
      r       = lcg_next();
      // junk pairs only while the decoder is busy
      ival    = garbage & ~ordy;
      isop    = ival & r[12];
      ieop    = ival & r[13];
      isoft_a = r[5 : 0];
      isoft_b = r[11 : 6];
      if (ocode_val) begin
        seen   = 1'b1;
        code   = ocode;
        metric = ometric;
      end
    end
    if (!seen) flag_error("timeout waiting for ocode_val");
  endtask

  // let the pulse end so it gets counted
  task automatic wait_ocode_low();
    int guard;
    guard = 0;
    while (ocode_val && guard < 100) begin
      @(negedge iclk);
      guard++;
      iclkena = 1'b1;
      ival    = 1'b0;
    end
    if (ocode_val) flag_error("ocode_val stuck high after a result");
  endtask

  task automatic run_frame(input int f, input int gap_pct, input int hole_pct,
                           input logic garbage);
    int        base;
    int        pulses;
    logic      seen;
    pls_code_t code;
    metric_t   metric;
    base   = f * cFRAME_WORDS;
    pulses = pulse_cnt;
    send_frame(f, gap_pct, hole_pct);
    wait_result(hole_pct, garbage, seen, code, metric);
    if (seen) begin
      check_code(code, pls_code_t'(golden_mem[base + cPAIR_NUM]));
      check_metric(metric, metric_t'(golden_mem[base + cPAIR_NUM + 1]));
    end
    wait_ocode_low();
    if (pulse_cnt - pulses != 1) begin
      flag_error($sformatf("frame %0d gave %0d ocode_val pulses instead of one",
                           f, pulse_cnt - pulses));
    end
  endtask

  task automatic finish_test(input int num, input string name);
    $display("test %0d %s, %0d errors", num, name, err_cnt - test_err);
    test_err = err_cnt;
  endtask

  initial begin
    ireset  = 1'b1;
    iclkena = 1'b1;
    isop    = 1'b0;
    ival    = 1'b0;
    ieop    = 1'b0;
    isoft_a = '0;
    isoft_b = '0;
    $readmemh("verif/pls_golden.txt", golden_mem);
    if ($isunknown(golden_mem[cFRAME_WORDS - 1]) || golden_mem[cFRAME_WORDS - 1] == '0) begin
      flag_error("golden file did not load");
    end

    // outputs quiet while reset is held
    for (int i = 0; i < 8; i++) begin
      @(negedge iclk);
      check_level("ordy", ordy, 1'b0);
      check_level("ocode_val", ocode_val, 1'b0);
    end
    ireset = 1'b0;
    wait_ordy();
    check_level("ocode_val", ocode_val, 1'b0);
    finish_test(1, "reset");

    // frames 0..3 are clean codewords, 4..5 carry noise
    for (int f = 0; f < 4; f++) run_frame(f, 0, 0, 1'b0);
    finish_test(2, "clean frames");
    for (int f = 4; f < cFRAME_NUM; f++) run_frame(f, 0, 0, 1'b0);
    finish_test(3, "noisy frames");
    for (int f = 0; f < cFRAME_NUM; f++) run_frame(f, 35, 0, 1'b0);
    finish_test(4, "ival gaps");
    for (int f = 0; f < cFRAME_NUM; f++) run_frame(f, 20, 30, 1'b0);
    finish_test(5, "clock enable holes");
    // junk during each decode, next frame must still match
    for (int i = 0; i < cFRAME_NUM; i++) run_frame(cFRAME_NUM - 1 - i, 10, 15, 1'b1);
    finish_test(6, "back pressure");

    $display("checks %0d, errors %0d", chk_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: verif/pls_golden.txt
// each line is one frame of 32 pairs {a[5:0], b[5:0]} in 3 hex digits, pair 0 first
// the last two words are the expected 7-bit code and the expected 12-bit metric
28A 28A 28A 28A 28A 28A 28A 28A 28A 28A 28A 28A 28A 28A 28A 28A 28A 28A 28A 28A 28A 28A 28A 28A 28A 28A 28A 28A 28A 28A 28A 28A 00 280
DB6 28A DB6 28A 28A DB6 28A DB6 DB6 28A DB6 28A 28A DB6 28A DB6 DB6 28A DB6 28A 28A DB6 28A DB6 DB6 28A DB6 28A 28A DB6 28A DB6 0B 280
2B6 2B6 D8A D8A 2B6 2B6 D8A D8A 2B6 2B6 D8A D8A 2B6 2B6 D8A D8A D8A D8A 2B6 2B6 D8A D8A 2B6 2B6 D8A D8A 2B6 2B6 D8A D8A 2B6 2B6 64 280
D8A 2B6 2B6 D8A 2B6 D8A D8A 2B6 2B6 D8A D8A 2B6 D8A 2B6 2B6 D8A 2B6 D8A D8A 2B6 D8A 2B6 2B6 D8A D8A 2B6 2B6 D8A 2B6 D8A D8A 2B6 7F 280
DB6 DB6 DB6 F36 DB6 DB6 DB6 DB6 DB6 DB6 DB6 DB6 D82 DB6 DB6 DB6 DB6 DB6 DB6 DB6 C76 DB6 DB6 DB6 DB6 DB6 DB6 DBA DB6 DB6 DB6 DB6 01 26F
2B6 0F6 D8A D8A 2B6 2B6 DBF D8A 2B6 2B6 D8A D8A 2B6 2B6 D8A D8A D8A BCA 2B6 2B6 D8A D8A 2B6 2B6 D8A D8A 2B6 2B6 D8A D8A 2B2 2B6 64 279

// File: verilog/pls_dec_ctrl.sv
// pls decoder controller: input flow control, pair fold and sort read sequence
`timescale 1ns/1ps
`default_nettype none

module pls_dec_ctrl import pls_dec_types_pkg::*, pls_dec_frame_pkg::*; (
  input  logic      iclk,
  input  logic      ireset,
  input  logic      iclkena,
  input  logic      isop,
  input  logic      ival,
  input  logic      ieop,
  input  soft_t     isoft_a,
  input  soft_t     isoft_b,
  output logic      ordy,
  pls_pair_if.master pair,
  pls_sort_if.master sort,
  input  logic      had_done_s,
  input  logic      had_done_d
);

  typedef enum logic [1 : 0] {
    cRESET_STATE,
    cWAIT_STATE,
    cWAIT_CORR_STATE,
    cREAD_STATE
  } state_t;

  state_t   state;
  logic     accept;
  logic     done_s_seen;
  logic     done_d_seen;
  row_idx_t pair_cnt;
  row_idx_t pair_idx;
  row_idx_t rd_cnt;
  logic     rd_last;

  // input taken only while waiting
  assign ordy     = (state == cWAIT_STATE);
  assign accept   = ival & ordy;
  // sop restarts the index
  assign pair_idx = isop ? '0 : pair_cnt;
  assign rd_last  = (rd_cnt == row_idx_t'(cROW_NUM - 1));

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      state <= cRESET_STATE;
    end else if (iclkena) begin
      case (state)
        cRESET_STATE     : state <= cWAIT_STATE;
        cWAIT_STATE      : state <= (accept & ieop) ? cWAIT_CORR_STATE : cWAIT_STATE;
        cWAIT_CORR_STATE : state <= (done_s_seen & done_d_seen) ? cREAD_STATE
                                                                 : cWAIT_CORR_STATE;
        cREAD_STATE      : state <= rd_last ? cWAIT_STATE : cREAD_STATE;
        default          : state <= cRESET_STATE;
      endcase
    end
  end

  // pair count and done latches
  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      pair_cnt    <= '0;
      rd_cnt      <= '0;
      done_s_seen <= 1'b0;
      done_d_seen <= 1'b0;
      pair.val    <= 1'b0;
      pair.eop    <= 1'b0;
    end else if (iclkena) begin
      pair.val <= accept;
      pair.eop <= accept & ieop;
      if (accept) begin
        // wraps after the last pair of a frame
        pair_cnt <= pair_idx + 1'b1;
      end
      // done pulses may come in different cycles
      if (state == cREAD_STATE) begin
        done_s_seen <= 1'b0;
        done_d_seen <= 1'b0;
        rd_cnt      <= rd_cnt + 1'b1;
      end else begin
        done_s_seen <= done_s_seen | had_done_s;
        done_d_seen <= done_d_seen | had_done_d;
      end
    end
  end

  // folded payload
  always_ff @(posedge iclk) begin
    if (iclkena && accept) begin
      pair.idx  <= pair_idx;
      pair.sum  <= pair_t'(isoft_a) + pair_t'(isoft_b);
      pair.diff <= pair_t'(isoft_a) - pair_t'(isoft_b);
    end
  end

  // read framing straight from the counter
  assign sort.val = (state == cREAD_STATE);
  assign sort.sop = sort.val & (rd_cnt == '0);
  assign sort.eop = sort.val & rd_last;
  assign sort.idx = rd_cnt;

endmodule

`default_nettype wire

// File: verilog/pls_dec_frame_pkg.sv
// pls decoder frame constants: pair count, index width and code bit layout
`default_nettype none

package pls_dec_frame_pkg;

  // pairs per pls header
  localparam int cPAIR_NUM      = 32;

  // reed-muller rows per correlator path
  localparam int cROW_NUM       = 32;

  // bits of a pair or row index
  localparam int cIDX_W         = $clog2(cPAIR_NUM);

  // code layout, path on top, sign at the bottom, row in between
  localparam int cCODE_PATH_BIT = 6;
  localparam int cCODE_SIGN_BIT = 0;

endpackage

`default_nettype wire

// File: verilog/pls_dec_if.sv
// pls decoder internal buses: folded pair stream and sort read sequence
`timescale 1ns/1ps
`default_nettype none

// folded pair stream, controller to both correlators
interface pls_pair_if import pls_dec_types_pkg::*; ();

  logic     val;
  logic     eop;
  row_idx_t idx;
  pair_t    sum;
  pair_t    diff;

  modport master (output val, eop, idx, sum, diff);
  modport slave  (input  val, eop, idx, sum, diff);

endinterface

// sort read sequence, controller to correlators and sort block
interface pls_sort_if import pls_dec_types_pkg::*; ();

  logic     sop;
  logic     val;
  logic     eop;
  // row to read out
  row_idx_t idx;

  modport master (output sop, val, eop, idx);
  modport slave  (input  sop, val, eop, idx);

endinterface

`default_nettype wire

// File: verilog/pls_dec_types_pkg.sv
// pls decoder types: vector widths for soft values, folds, correlations and codes
`default_nettype none

package pls_dec_types_pkg;

  // one soft symbol, positive means bit 0
  typedef logic signed [5 : 0] soft_t;

  // sum or difference of two soft symbols
  typedef logic signed [6 : 0] pair_t;

  // correlation accumulator over 32 folds
  // worst case is 32 * -64, still inside 12 bits
  typedef logic signed [11 : 0] corr_t;

  // magnitude of a correlation
  typedef logic [11 : 0] metric_t;

  // decoded code {path, row, sign}
  typedef logic [6 : 0] pls_code_t;

  // pair index or reed-muller row index
  typedef logic [4 : 0] row_idx_t;

endpackage

`default_nettype wire

// File: verilog/pls_decoder.sv
// pls decoder top: controller, sum and difference correlators, max sort
`timescale 1ns/1ps
`default_nettype none

module pls_decoder import pls_dec_types_pkg::*; (
  input  logic      iclk,
  input  logic      ireset,
  input  logic      iclkena,
  input  logic      isop,
  input  logic      ival,
  input  logic      ieop,
  input  soft_t     isoft_a,
  input  soft_t     isoft_b,
  output logic      ordy,
  output logic      ocode_val,
  output pls_code_t ocode,
  output metric_t   ometric
);

  pls_pair_if pair_bus ();
  pls_sort_if sort_bus ();

  logic  done_s;
  logic  done_d;
  corr_t corr_s;
  corr_t corr_d;

  pls_dec_ctrl u_ctrl (
    .iclk       (iclk),
    .ireset     (ireset),
    .iclkena    (iclkena),
    .isop       (isop),
    .ival       (ival),
    .ieop       (ieop),
    .isoft_a    (isoft_a),
    .isoft_b    (isoft_b),
    .ordy       (ordy),
    .pair       (pair_bus.master),
    .sort       (sort_bus.master),
    .had_done_s (done_s),
    .had_done_d (done_d)
  );

  // sum path
  pls_rm_corr u_corr_s (
    .iclk    (iclk),
    .ireset  (ireset),
    .iclkena (iclkena),
    .fold    (pair_bus.sum),
    .pair    (pair_bus.slave),
    .sort    (sort_bus.slave),
    .done    (done_s),
    .corr    (corr_s)
  );

  // difference path
  pls_rm_corr u_corr_d (
    .iclk    (iclk),
    .ireset  (ireset),
    .iclkena (iclkena),
    .fold    (pair_bus.diff),
    .pair    (pair_bus.slave),
    .sort    (sort_bus.slave),
    .done    (done_d),
    .corr    (corr_d)
  );

  pls_max_sort u_sort (
    .iclk      (iclk),
    .ireset    (ireset),
    .iclkena   (iclkena),
    .sort      (sort_bus.slave),
    .corr_s    (corr_s),
    .corr_d    (corr_d),
    .ocode_val (ocode_val),
    .ocode     (ocode),
    .ometric   (ometric)
  );

endmodule

`default_nettype wire

// File: verilog/pls_max_sort.sv
// max magnitude search over sum and difference correlations, forms the pls code
`timescale 1ns/1ps
`default_nettype none

module pls_max_sort import pls_dec_types_pkg::*, pls_dec_frame_pkg::*; (
  input  logic      iclk,
  input  logic      ireset,
  input  logic      iclkena,
  pls_sort_if.slave sort,
  input  corr_t     corr_s,
  input  corr_t     corr_d,
  output logic      ocode_val,
  output pls_code_t ocode,
  output metric_t   ometric
);

  function automatic metric_t abs_corr(input corr_t c);
    // -2048 maps onto 2048 as unsigned
    return c[$bits(corr_t)-1] ? metric_t'(-c) : metric_t'(c);
  endfunction

  function automatic pls_code_t make_code(input logic path, input row_idx_t k,
                                          input logic sign);
    pls_code_t code;
    code                                        = '0;
    code[cCODE_PATH_BIT]                        = path;
    code[cCODE_PATH_BIT-1 : cCODE_SIGN_BIT+1]   = k;
    code[cCODE_SIGN_BIT]                        = sign;
    return code;
  endfunction

  logic      sop_d;
  logic      val_d;
  logic      eop_d;
  row_idx_t  idx_d;
  metric_t   best_mag;
  pls_code_t best_code;
  metric_t   cand_mag;
  pls_code_t cand_code;

  // framing lined up with the registered correlations
  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      sop_d <= 1'b0;
      val_d <= 1'b0;
      eop_d <= 1'b0;
    end else if (iclkena) begin
      sop_d <= sort.sop & sort.val;
      val_d <= sort.val;
      eop_d <= sort.eop & sort.val;
    end
  end

  always_ff @(posedge iclk) begin
    if (iclkena) begin
      idx_d <= sort.idx;
    end
  end

  // sum first, then diff, strict compare keeps the earlier on a tie
  always_comb begin
    cand_mag  = sop_d ? '0 : best_mag;
    cand_code = sop_d ? '0 : best_code;
    if (abs_corr(corr_s) > cand_mag) begin
      cand_mag  = abs_corr(corr_s);
      cand_code = make_code(1'b0, idx_d, corr_s[$bits(corr_t)-1]);
    end
    if (abs_corr(corr_d) > cand_mag) begin
      cand_mag  = abs_corr(corr_d);
      cand_code = make_code(1'b1, idx_d, corr_d[$bits(corr_t)-1]);
    end
  end

  // running best and result
  always_ff @(posedge iclk) begin
    if (iclkena && val_d) begin
      best_mag  <= cand_mag;
      best_code <= cand_code;
      if (eop_d) begin
        ocode   <= cand_code;
        ometric <= cand_mag;
      end
    end
  end

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      ocode_val <= 1'b0;
    end else if (iclkena) begin
      ocode_val <= val_d & eop_d;
    end
  end

endmodule

`default_nettype wire

// File: verilog/pls_rm_corr.sv
// reed-muller correlator: 32 accumulators against one folded stream, read by index
`timescale 1ns/1ps
`default_nettype none

module pls_rm_corr import pls_dec_types_pkg::*, pls_dec_frame_pkg::*; (
  input  logic      iclk,
  input  logic      ireset,
  input  logic      iclkena,
  // sum or difference, chosen by the instance
  input  pair_t     fold,
  pls_pair_if.slave pair,
  pls_sort_if.slave sort,
  output logic      done,
  output corr_t     corr
);

  corr_t acc [cROW_NUM];
  corr_t fold_ext;
  logic  first;

  // sign extended to accumulator width
  assign fold_ext = corr_t'(fold);
  // pair 0 starts a new frame
  assign first    = (pair.idx == '0);

  for (genvar k = 0; k < cROW_NUM; k++) begin : g_acc
    logic  neg;
    corr_t base;

    // row sign is the parity of idx and k
    assign neg  = ^(pair.idx & cIDX_W'(k));
    assign base = first ? '0 : acc[k];

    always_ff @(posedge iclk) begin
      if (iclkena && pair.val) begin
        acc[k] <= neg ? (base - fold_ext) : (base + fold_ext);
      end
    end
  end

  // one cycle after the eop beat
  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      done <= 1'b0;
    end else if (iclkena) begin
      done <= pair.val & pair.eop;
    end
  end

  // registered read out for the sort block
  always_ff @(posedge iclk) begin
    if (iclkena && sort.val) begin
      corr <= acc[sort.idx];
    end
  end

endmodule

`default_nettype wire
